// ==== src/iccm_pkg.sv ====
/*
 * Shared types and constants for the interleaved instruction CCM.
 * Four banks of 39-bit words (32 data bits plus 7 check bits), selected
 * by byte address bits 3:2. Modules pull these in with a wildcard import.
 */

package iccm_pkg;

   localparam int NUM_BANKS = 4;  // Bank number is address bits 3:2
   localparam int WORD_BITS = 39;

   typedef logic [WORD_BITS-1:0] iccm_word_t;

   // Write data and raw read data, even bank word in lo
   typedef struct packed {
      iccm_word_t hi;
      iccm_word_t lo;
   } iccm_dword_t;

   typedef iccm_word_t [NUM_BANKS-1:0] iccm_bank_words_t;

   typedef logic [NUM_BANKS-1:0] iccm_bank_mask_t;

   // Access size, sets the halfword step to the second bank
   typedef enum logic [1:0] {
      SIZE_WORD  = 2'b10,  // One halfword step
      SIZE_DWORD = 2'b11   // Two halfword steps
   } iccm_size_e;

   // Per-cycle access control
   typedef struct packed {
      logic       wren;
      logic       rden;
      iccm_size_e size;
      logic       correct;     // Correction cycle, loads a redundant row
      logic       corr_state;  // Correction in progress
   } iccm_ctl_t;

endpackage

// ==== src/iccm_bank_decode.sv ====
/*
 * Access decode for the interleaved banks.
 * Turns one word or doubleword access into per-bank enables, row indices
 * and write data. Purely combinational, used in the access cycle.
 */

`timescale 1ns/1ps

module iccm_bank_decode
   import iccm_pkg::*;
#(
   parameter int ICCM_BITS = 10
) (
   input  iccm_ctl_t                             ctl,
   input  logic [ICCM_BITS-1:1]                  rw_addr,       // Halfword address
   input  iccm_dword_t                           wr_data,
   output logic [ICCM_BITS-1:1]                  addr_inc,      // Address of second half
   output iccm_bank_mask_t                       bank_wren,
   output iccm_bank_mask_t                       bank_rden,
   output logic [NUM_BANKS-1:0][ICCM_BITS-1:4]   bank_row,
   output iccm_bank_words_t                      bank_wr_data
);

   logic [1:0]           addr_step;
   iccm_bank_mask_t      hit_lo;  // Bank of rw_addr
   iccm_bank_mask_t      hit_hi;  // Bank of addr_inc

   assign addr_step = (ctl.size == SIZE_DWORD) ? 2'd2 : 2'd1;
   assign addr_inc  = rw_addr + (ICCM_BITS-1)'(addr_step);

   // **************************************************************************
   // Per-bank commands
   // **************************************************************************
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      assign hit_lo[i] = (rw_addr[3:2] == 2'(i));
      assign hit_hi[i] = (addr_inc[3:2] == 2'(i));

      assign bank_wren[i] = ctl.wren & (hit_lo[i] | hit_hi[i]);
      assign bank_rden[i] = ctl.rden & (hit_lo[i] | hit_hi[i]);

      // Second word past bank 3 lands in bank 0 of the next row
      assign bank_row[i] = hit_lo[i] ? rw_addr[ICCM_BITS-1:4] : addr_inc[ICCM_BITS-1:4];

      if (i % 2 == 1) begin : g_odd
         assign bank_wr_data[i] = wr_data.hi;
      end else begin : g_even
         assign bank_wr_data[i] = wr_data.lo;
      end
   end

endmodule

// ==== src/iccm_bank_ram.sv ====
/*
 * One bank of the instruction CCM.
 * Single-port behavioral RAM, one row per access. Writes land at the
 * clock edge; read data is registered and held while re is low.
 */

`timescale 1ns/1ps

module iccm_bank_ram
   import iccm_pkg::*;
#(
   parameter int INDEX_BITS = 6
) (
   input  logic                  clk,
   input  logic                  we,
   input  logic                  re,
   input  logic [INDEX_BITS-1:0] row,
   input  iccm_word_t            wr_word,
   output iccm_word_t            rd_word
);

   iccm_word_t mem [2**INDEX_BITS];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[row] <= wr_word;
      end
      if (re) begin
         rd_word <= mem[row];  // Old contents on a same-cycle write
      end
   end

endmodule

// ==== src/iccm_redundancy.sv ====
/*
 * Redundant rows for hard faults in the instruction CCM.
 * Two word-sized rows, each with an address and a valid bit, are loaded
 * on correction cycles and picked by an LRU bit. Accesses are matched
 * in the access cycle; one cycle later matching bank outputs are
 * replaced by the row data. Writes to a replaced word update its row.
 */

`timescale 1ns/1ps

module iccm_redundancy
   import iccm_pkg::*;
#(
   parameter int ICCM_BITS = 10
) (
   input  logic                 clk,
   input  logic                 rst,
   input  iccm_ctl_t            ctl,
   input  logic [ICCM_BITS-1:1] rw_addr,
   input  logic [ICCM_BITS-1:1] addr_inc,
   input  iccm_dword_t          wr_data,
   input  iccm_bank_words_t     bank_dout,     // Raw bank read data
   output iccm_bank_words_t     bank_dout_fn   // After substitution
);

   localparam int NUM_ROWS = 2;

   logic [NUM_ROWS-1:0][ICCM_BITS-1:2] row_addr;   // Word address of each row
   iccm_word_t [NUM_ROWS-1:0]          row_data;
   logic [NUM_ROWS-1:0]                row_valid;
   logic                               row_lru;    // Row replaced next

   iccm_bank_mask_t [NUM_ROWS-1:0]     sel_row;
   iccm_bank_mask_t [NUM_ROWS-1:0]     sel_row_q;

   logic [NUM_ROWS-1:0]                row_load;
   logic [NUM_ROWS-1:0]                row_wr_hit;
   logic [NUM_ROWS-1:0]                row_bit2;   // Address bit 2 the data follows
   iccm_word_t [NUM_ROWS-1:0]          row_data_in;

   logic                               dword;
   logic                               lru_en;
   logic                               lru_in;

   assign dword = (ctl.size == SIZE_DWORD);

   // **************************************************************************
   // Address match, per row and bank
   // **************************************************************************
   always_comb begin
      for (int r = 0; r < NUM_ROWS; r++) begin
         for (int b = 0; b < NUM_BANKS; b++) begin
            sel_row[r][b] = row_valid[r] &
               (((rw_addr[ICCM_BITS-1:2] == row_addr[r]) & (rw_addr[3:2] == 2'(b))) |
                ((addr_inc[ICCM_BITS-1:2] == row_addr[r]) & (addr_inc[3:2] == 2'(b))));
         end
      end
   end

   // **************************************************************************
   // Row load and update
   // **************************************************************************
   always_comb begin
      for (int r = 0; r < NUM_ROWS; r++) begin
         row_load[r] = ctl.correct & (row_lru == 1'(r));

         // Word write matches to bit 2, doubleword write to bit 3
         row_wr_hit[r] = row_valid[r] & ctl.wren &
                         (rw_addr[ICCM_BITS-1:3] == row_addr[r][ICCM_BITS-1:3]) &
                         ((rw_addr[2] == row_addr[r][2]) | dword);

         row_bit2[r] = row_load[r] ? rw_addr[2] : row_addr[r][2];

         // Odd word of the pair comes from the hi half
         row_data_in[r] = (row_bit2[r] & (rw_addr[2] | dword)) ? wr_data.hi : wr_data.lo;
      end
   end

   // Correction flips the LRU; a hit during correction points it away
   assign lru_en = ctl.correct |
                   (ctl.rden & ctl.corr_state & ((|sel_row[0]) | (|sel_row[1])));
   assign lru_in = ctl.correct ? ~row_lru : (|sel_row[0]);

   always_ff @(posedge clk) begin
      if (rst) begin
         row_valid <= '0;
         row_lru   <= 1'b0;
         sel_row_q <= '0;
      end else begin
         sel_row_q <= sel_row;
         if (lru_en) begin
            row_lru <= lru_in;
         end
         for (int r = 0; r < NUM_ROWS; r++) begin
            if (row_load[r]) begin
               row_valid[r] <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int r = 0; r < NUM_ROWS; r++) begin
         if (row_load[r]) begin
            row_addr[r] <= rw_addr[ICCM_BITS-1:2];
         end
         if (row_load[r] | row_wr_hit[r]) begin
            row_data[r] <= row_data_in[r];
         end
      end
   end

   // **************************************************************************
   // Output substitution, row 1 first
   // **************************************************************************
   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         if (sel_row_q[1][b]) begin
            bank_dout_fn[b] = row_data[1];
         end else if (sel_row_q[0][b]) begin
            bank_dout_fn[b] = row_data[0];
         end else begin
            bank_dout_fn[b] = bank_dout[b];
         end
      end
   end

endmodule

// ==== src/iccm_read_align.sv ====
/*
 * Read data steering for the instruction CCM.
 * Captures the bank numbers and halfword bit of an access, then in the
 * next cycle picks the two bank words and aligns 64 bits to the halfword.
 */

`timescale 1ns/1ps

module iccm_read_align
   import iccm_pkg::*;
#(
   parameter int ICCM_BITS = 10
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [ICCM_BITS-1:1] rw_addr,
   input  logic [ICCM_BITS-1:1] addr_inc,
   input  iccm_bank_words_t     bank_dout_fn,
   output logic [63:0]          rd_data,
   output iccm_dword_t          rd_data_ecc
);

   logic [3:1]  rd_addr_lo_q;  // Bank and halfword of rw_addr
   logic [3:2]  rd_addr_hi_q;  // Bank of addr_inc
   logic [63:0] rd_data_pre;

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_addr_lo_q <= '0;
         rd_addr_hi_q <= '0;
      end else begin
         rd_addr_lo_q <= rw_addr[3:1];
         rd_addr_hi_q <= addr_inc[3:2];
      end
   end

   assign rd_data_ecc.lo = bank_dout_fn[rd_addr_lo_q[3:2]];
   assign rd_data_ecc.hi = bank_dout_fn[rd_addr_hi_q];

   // Data bits only, check bits dropped
   assign rd_data_pre = {rd_data_ecc.hi[31:0], rd_data_ecc.lo[31:0]};

   assign rd_data = rd_addr_lo_q[1] ? {16'b0, rd_data_pre[63:16]}  // Odd halfword
                                    : rd_data_pre;

endmodule

// ==== src/iccm_mem_top.sv ====
/*
 * Instruction closely-coupled memory, four interleaved 39-bit banks.
 * Accepts one access per cycle with no handshake. Read data is valid
 * one cycle after a read; a write is visible to the next cycle's read.
 * Two redundant rows stand in for faulty words.
 */

`timescale 1ns/1ps

module iccm_mem_top
   import iccm_pkg::*;
#(
   parameter int ICCM_BITS = 10  // Byte address width
) (
   input  logic                 clk,
   input  logic                 rst,
   input  iccm_ctl_t            ctl,
   input  logic [ICCM_BITS-1:1] rw_addr,
   input  iccm_dword_t          wr_data,
   output logic [63:0]          rd_data,
   output iccm_dword_t          rd_data_ecc
);

   localparam int INDEX_BITS = ICCM_BITS - 4;  // Rows per bank

   logic [ICCM_BITS-1:1]                addr_inc;
   iccm_bank_mask_t                     bank_wren;
   iccm_bank_mask_t                     bank_rden;
   logic [NUM_BANKS-1:0][ICCM_BITS-1:4] bank_row;
   iccm_bank_words_t                    bank_wr_data;
   iccm_bank_words_t                    bank_dout;
   iccm_bank_words_t                    bank_dout_fn;

   iccm_bank_decode #(.ICCM_BITS(ICCM_BITS)) u_decode (
      .ctl          (ctl),
      .rw_addr      (rw_addr),
      .wr_data      (wr_data),
      .addr_inc     (addr_inc),
      .bank_wren    (bank_wren),
      .bank_rden    (bank_rden),
      .bank_row     (bank_row),
      .bank_wr_data (bank_wr_data)
   );

   // **************************************************************************
   // Memory banks
   // **************************************************************************
   for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
      iccm_bank_ram #(.INDEX_BITS(INDEX_BITS)) u_ram (
         .clk     (clk),
         .we      (bank_wren[i]),
         .re      (bank_rden[i]),
         .row     (bank_row[i]),
         .wr_word (bank_wr_data[i]),
         .rd_word (bank_dout[i])
      );
   end

   iccm_redundancy #(.ICCM_BITS(ICCM_BITS)) u_redundancy (
      .clk          (clk),
      .rst          (rst),
      .ctl          (ctl),
      .rw_addr      (rw_addr),
      .addr_inc     (addr_inc),
      .wr_data      (wr_data),
      .bank_dout    (bank_dout),
      .bank_dout_fn (bank_dout_fn)
   );

   iccm_read_align #(.ICCM_BITS(ICCM_BITS)) u_read_align (
      .clk          (clk),
      .rst          (rst),
      .rw_addr      (rw_addr),
      .addr_inc     (addr_inc),
      .bank_dout_fn (bank_dout_fn),
      .rd_data      (rd_data),
      .rd_data_ecc  (rd_data_ecc)
   );

endmodule

// ==== test/tb_clock_gen.sv ====
/*
 * Clock and reset source for the ICCM testbench.
 * Free-running clock, reset held high for a set number of rising edges
 * and released just after the last of them.
 */

`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int PERIOD_NS    = 10,
   parameter int RESET_CYCLES = 2
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;  // Released on the edge, like a flop
   end

endmodule

// ==== test/iccm_mem_checker.sv ====
/*
 * Concurrent assertions on the redundant-row logic of the ICCM.
 * Bound into every iccm_redundancy instance; watches the correction
 * control, the LRU bit and the row valid bits.
 */

`timescale 1ns/1ps

module iccm_mem_checker (
   input logic       clk,
   input logic       rst,
   input logic       correct,    // Correction cycle
   input logic       row_lru,
   input logic [1:0] row_valid
);

   int fail_count = 0;  // Failed assertions so far

   // **************************************************************************
   // Correction cycle
   // **************************************************************************
   a_corr_flips_lru: assert property (@(posedge clk) disable iff (rst)
      correct |=> (row_lru != $past(row_lru)))
      else begin
         fail_count = fail_count + 1;
         $error("LRU bit did not toggle after a correction cycle");
      end

   a_corr_row0_valid: assert property (@(posedge clk) disable iff (rst)
      (correct && !row_lru) |=> row_valid[0])
      else begin
         fail_count = fail_count + 1;
         $error("Row 0 not valid after a correction that chose it");
      end

   a_corr_row1_valid: assert property (@(posedge clk) disable iff (rst)
      (correct && row_lru) |=> row_valid[1])
      else begin
         fail_count = fail_count + 1;
         $error("Row 1 not valid after a correction that chose it");
      end

   // Both rows start out empty
   a_reset_clears_rows: assert property (@(posedge clk)
      rst |=> (row_valid == 2'b00))
      else begin
         fail_count = fail_count + 1;
         $error("Redundant rows still valid after reset");
      end

endmodule

bind iccm_redundancy iccm_mem_checker u_checker (
   .clk       (clk),
   .rst       (rst),
   .correct   (ctl.correct),
   .row_lru   (row_lru),
   .row_valid (row_valid)
);

// ==== test/iccm_mem_tb.sv ====
/*
 * Testbench for the interleaved instruction CCM.
 * Reads commands and expected read data from test/iccm_mem_stim.txt,
 * applies one command per cycle and checks each read one cycle later.
 * Run from the project root so the stim file path resolves.
 */

`timescale 1ns/1ps

module iccm_mem_tb
   import iccm_pkg::*;
();

   localparam int          ICCM_BITS = 10;
   localparam int          FIELDS    = 8;     // Values per stim line
   localparam int          MAX_LINES = 256;
   localparam logic [63:0] OP_READ   = 64'h3; // Ops above this end the list
   localparam iccm_ctl_t   IDLE_CTL  = '{1'b0, 1'b0, SIZE_WORD, 1'b0, 1'b0};

   logic                 clk;
   logic                 rst;
   iccm_ctl_t            ctl;
   logic [ICCM_BITS-1:1] rw_addr;
   iccm_dword_t          wr_data;
   logic [63:0]          rd_data;
   iccm_dword_t          rd_data_ecc;

   logic [63:0] stim [FIELDS*MAX_LINES];
   int          num_lines;
   int          cycle_limit   = 0;
   int          cycle_count   = 0;
   int          reads_checked = 0;
   int          rd_errors     = 0;
   int          ecc_errors    = 0;
   int          load_errors   = 0;
   int          assert_errors = 0;
   int          pending;  // Index of the read awaiting data or -1

   tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(2)) u_clk_gen (
      .clk (clk),
      .rst (rst)
   );

   iccm_mem_top #(.ICCM_BITS(ICCM_BITS)) UUT (
      .clk         (clk),
      .rst         (rst),
      .ctl         (ctl),
      .rw_addr     (rw_addr),
      .wr_data     (wr_data),
      .rd_data     (rd_data),
      .rd_data_ecc (rd_data_ecc)
   );

   // **************************************************************************
   // Stimulus and checking
   // **************************************************************************
   task automatic apply_record(input int n);
      int b;
      b = n * FIELDS;
      ctl        <= iccm_ctl_t'(stim[b+1][5:0]);
      rw_addr    <= stim[b+2][ICCM_BITS-1:1];  // Byte address to halfword
      wr_data.hi <= stim[b+3][WORD_BITS-1:0];
      wr_data.lo <= stim[b+4][WORD_BITS-1:0];
   endtask

   task automatic go_idle();
      ctl     <= IDLE_CTL;
      rw_addr <= '0;
      wr_data <= '0;
   endtask

   task automatic check_read(input int n);
      int                   b;
      logic [ICCM_BITS-1:0] addr;
      logic [63:0]          exp_rd;
      iccm_dword_t          exp_ecc;
      b          = n * FIELDS;
      addr       = stim[b+2][ICCM_BITS-1:0];
      exp_rd     = stim[b+5];
      exp_ecc.hi = stim[b+6][WORD_BITS-1:0];
      exp_ecc.lo = stim[b+7][WORD_BITS-1:0];
      reads_checked++;
      assert (rd_data === exp_rd) else begin
         rd_errors++;
         $display("** Error at time %0t: rd_data of read at 0x%03h is %016h, expected %016h",
                  $time, addr, rd_data, exp_rd);
      end
      assert (rd_data_ecc === exp_ecc) else begin
         ecc_errors++;
         $display("** Error at time %0t: rd_data_ecc of read at 0x%03h is %020h, expected %020h",
                  $time, addr, rd_data_ecc, exp_ecc);
      end
   endtask

   // Limit scales with the stim length
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
         $display("Timeout after %0d cycles, the stimulus did not finish", cycle_count);
         $display("Errors found");
         $finish;
      end
   end

   initial begin
      ctl     = IDLE_CTL;
      rw_addr = '0;
      wr_data = '0;
      for (int i = 0; i < FIELDS * MAX_LINES; i++) begin
         stim[i] = '1;  // Unloaded entries read as end of list
      end
      $readmemh("test/iccm_mem_stim.txt", stim);
      num_lines = 0;
      while (num_lines < MAX_LINES && stim[num_lines*FIELDS] <= OP_READ) begin
         num_lines++;
      end
      cycle_limit = 4 * num_lines + 50;
      if (num_lines == 0) begin
         load_errors++;
         $display("Stimulus file test/iccm_mem_stim.txt is missing or holds no commands");
      end

      @(negedge rst);
      pending = -1;
      for (int n = 0; n < num_lines; n++) begin
         @(posedge clk);
         apply_record(n);
         @(negedge clk);  // Outputs of the previous access are settled
         if (pending >= 0) begin
            check_read(pending);
         end
         pending = (stim[n*FIELDS] == OP_READ) ? n : -1;
      end
      @(posedge clk);
      go_idle();
      @(negedge clk);
      if (pending >= 0) begin
         check_read(pending);
      end

      // Failures of the bound redundancy assertions
      assert_errors = UUT.u_redundancy.u_checker.fail_count;

      $display("Reads: %0d, errors rd_data %0d, rd_data_ecc %0d, load %0d, assertion %0d",
               reads_checked, rd_errors, ecc_errors, load_errors, assert_errors);
      if (rd_errors + ecc_errors + load_errors + assert_errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== test/iccm_mem_stim.txt ====
// Columns: op ctl addr wr_hi wr_lo exp_rd_data exp_ecc_hi exp_ecc_lo
// op 0 idle, 1 write, 2 correction, 3 read, f end; ctl {wren,rden,size,correct,corr_state}
// Word writes, one per bank, then back-to-back word reads
1 28 000 21B0000000 11A0000000 0 0 0
1 28 004 22B1111111 12A1111111 0 0 0
1 28 008 23B2222222 13A2222222 0 0 0
1 28 00C 24B3333333 14A3333333 0 0 0
3 18 000 0 0 A0000000A0000000 11A0000000 11A0000000
3 18 004 0 0 B1111111B1111111 22B1111111 22B1111111
3 18 008 0 0 A2222222A2222222 13A2222222 13A2222222
3 18 00C 0 0 B3333333B3333333 24B3333333 24B3333333
// Doubleword writes from each bank, the last wraps into bank 0 of row 3
1 2C 010 31C1010101 30D1010101 0 0 0
1 2C 018 33C2020202 32D2020202 0 0 0
1 2C 024 35C3030303 34D3030303 0 0 0
1 2C 02C 37C4040404 36D4040404 0 0 0
0 08 000 0 0 0 0 0
3 1C 010 0 0 C1010101D1010101 31C1010101 30D1010101
3 1C 018 0 0 C2020202D2020202 33C2020202 32D2020202
3 1C 014 0 0 D2020202C1010101 32D2020202 31C1010101
3 1C 024 0 0 D3030303C3030303 34D3030303 35C3030303
3 1C 02C 0 0 D4040404C4040404 36D4040404 37C4040404
// Halfword-aligned reads
3 1C 012 0 0 0000C1010101D101 31C1010101 30D1010101
3 1C 02E 0 0 0000D4040404C404 36D4040404 37C4040404
3 18 006 0 0 0000A2222222B111 13A2222222 22B1111111
// Correction loads row 0 with the odd word, reads see the row
2 0A 004 41E1111111 40F1111111 0 0 0
3 18 004 0 0 E1111111E1111111 41E1111111 41E1111111
3 1C 000 0 0 E1111111A0000000 41E1111111 11A0000000
// Row 1 loaded, then a corr_state hit on row 0 steers the LRU to row 1
2 0A 008 43E3333333 42F2222222 0 0 0
3 18 008 0 0 F2222222F2222222 42F2222222 42F2222222
3 19 004 0 0 E1111111E1111111 41E1111111 41E1111111
2 0A 010 45E5555555 44F4444444 0 0 0
3 18 008 0 0 A2222222A2222222 13A2222222 13A2222222
3 18 004 0 0 E1111111E1111111 41E1111111 41E1111111
3 18 010 0 0 F4444444F4444444 44F4444444 44F4444444
// Older row 0 replaced, then a write updates the row
2 0A 018 47E7777777 46F6666666 0 0 0
3 18 004 0 0 B1111111B1111111 22B1111111 22B1111111
3 18 018 0 0 F6666666F6666666 46F6666666 46F6666666
1 28 018 5313572468 5224681357 0 0 0
3 18 018 0 0 2468135724681357 5224681357 5224681357
// Back-to-back reads mixing memory and row data
3 1C 024 0 0 D3030303C3030303 34D3030303 35C3030303
3 1C 02E 0 0 0000D4040404C404 36D4040404 37C4040404
3 1C 010 0 0 C1010101F4444444 31C1010101 44F4444444
3 18 00C 0 0 B3333333B3333333 24B3333333 24B3333333
3 1C 016 0 0 000024681357C101 5224681357 31C1010101
F 0 0 0 0 0 0 0

// ==== iccm_mem.f ====
src/iccm_pkg.sv
src/iccm_bank_decode.sv
src/iccm_bank_ram.sv
src/iccm_redundancy.sv
src/iccm_read_align.sv
src/iccm_mem_top.sv
test/tb_clock_gen.sv
test/iccm_mem_checker.sv
test/iccm_mem_tb.sv

// ==== Makefile ====
# Verilator lint and simulation of the ICCM testbench

TOP := iccm_mem_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f iccm_mem.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-Mdir obj_dir -f iccm_mem.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
